//--- testbench/mdu_golden.txt
// op lop rop expected_result expected_flags (flags = div_zero,div_ovf), all hex
0 00000007 00000006 0000002a 0
0 fffffffd 00000005 fffffff1 0
0 fffffffc fffffff8 00000020 0
1 ffffffff 00000002 fffffffe 0
1 12345678 00000010 23456780 0
2 fffffffd 00000005 ffffffff 0
2 40000000 00000004 00000001 0
2 80000000 80000000 40000000 0
2 80000000 ffffffff 00000000 0
2 80000000 00000001 ffffffff 0
3 ffffffff ffffffff fffffffe 0
3 80000000 00000002 00000001 0
2 7fffffff 7fffffff 3fffffff 0
4 00000064 00000007 0000000e 0
4 ffffff9c 00000007 fffffff2 0
4 00000064 fffffff9 fffffff2 0
4 ffffff9c fffffff9 0000000e 0
6 00000064 00000007 00000002 0
6 ffffff9c 00000007 fffffffe 0
6 00000064 fffffff9 00000002 0
6 ffffff9c fffffff9 fffffffe 0
5 ffffff9c 00000007 24924916 0
7 ffffff9c 00000007 00000002 0
5 80000000 ffffffff 00000000 0
7 80000000 ffffffff 80000000 0
4 00000005 00000000 00000000 2
7 12345678 00000000 00000000 2
4 80000000 ffffffff 00000000 1
6 80000000 ffffffff 00000000 1
4 80000000 00000002 c0000000 0

//--- tb.f
+incdir+rtl
rtl/mdu_pkg.sv
rtl/mdu_ctrl_if.sv
rtl/mdu_ctrl.sv
rtl/mdu_operand_unit.sv
rtl/mdu_iter_unit.sv
rtl/mdu_result_unit.sv
rtl/mdu_top.sv
testbench/mdu_assertions.sv
testbench/mdu_checker.sv
testbench/tb_mdu.sv

//--- Bender.yml
package:
  name: mdu

export_include_dirs:
  - rtl

sources:
  - rtl/mdu_pkg.sv
  - rtl/mdu_ctrl_if.sv
  - rtl/mdu_ctrl.sv
  - rtl/mdu_operand_unit.sv
  - rtl/mdu_iter_unit.sv
  - rtl/mdu_result_unit.sv
  - rtl/mdu_top.sv
  - target: test
    files:
      - testbench/mdu_assertions.sv
      - testbench/mdu_checker.sv
      - testbench/tb_mdu.sv

//--- testbench/tb_mdu.sv
`default_nettype none

`include "mdu_params.svh"

module tb_mdu;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_vec    = 30;
  localparam int max_cycles = num_vec * (`MDU_WIDTH + 6) + 100;

  logic             clk = 1'b0;
  logic             rst_n;
  logic             valid;
  mdu_pkg::mdu_op_t op;
  mdu_pkg::word_t   lop;
  mdu_pkg::word_t   rop;
  mdu_pkg::word_t   result;
  logic             done;
  logic             div_zero;
  logic             div_ovf;
  logic             start;
  logic [7:0]       index;
  mdu_pkg::word_t   exp_result;
  logic [1:0]       exp_flags;
  int               tests;
  int               errors;
  int               fails;
  int               cycle_cnt = 0;
  mdu_pkg::word_t   golden [5*num_vec];  // op lop rop result flags per vector

  always #5 clk = ~clk;

  mdu_top u_mdu_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid),
    .op_i           (op),
    .lop_i          (lop),
    .rop_i          (rop),
    .result_o       (result),
    .done_o         (done),
    .div_by_zero_o  (div_zero),
    .div_overflow_o (div_ovf)
  );

  mdu_checker u_checker (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (start),
    .index_i        (index),
    .op_i           (op),
    .exp_result_i   (exp_result),
    .exp_flags_i    (exp_flags),
    .result_i       (result),
    .done_i         (done),
    .div_by_zero_i  (div_zero),
    .div_overflow_i (div_ovf),
    .tests_o        (tests),
    .errors_o       (errors)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    rst_n      = 1'b0;
    valid      = 1'b0;
    op         = '0;
    lop        = '0;
    rop        = '0;
    start      = 1'b0;
    index      = '0;
    exp_result = '0;
    exp_flags  = '0;
    $readmemh("testbench/mdu_golden.txt", golden);
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < num_vec; i++) begin
      valid      <= 1'b1;
      start      <= 1'b1;
      index      <= 8'(i);
      op         <= golden[5*i][2:0];
      lop        <= golden[5*i+1];
      rop        <= golden[5*i+2];
      exp_result <= golden[5*i+3];
      exp_flags  <= golden[5*i+4][1:0];
      @(posedge clk);
      valid <= 1'b0;  // operands stay put until done
      start <= 1'b0;
      do @(posedge clk); while (!done);
    end
    @(posedge clk);
    fails = u_mdu_top.u_ctrl.u_assertions.fail_cnt;
    $display("%0d tests, %0d failed, %0d assertion failures", tests, errors, fails);
    if (errors == 0 && fails == 0 && tests == num_vec + 1) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/mdu_checker.sv
`default_nettype none

`include "mdu_params.svh"

module mdu_checker (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             start_i,       // request goes out this cycle
  input  wire logic [7:0]       index_i,
  input  wire mdu_pkg::mdu_op_t op_i,
  input  wire mdu_pkg::word_t   exp_result_i,
  input  wire logic [1:0]       exp_flags_i,   // div_zero, div_ovf
  input  wire mdu_pkg::word_t   result_i,
  input  wire logic             done_i,
  input  wire logic             div_by_zero_i,
  input  wire logic             div_overflow_i,
  output int                    tests_o,
  output int                    errors_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic busy = 1'b0;
  logic in_rst = 1'b0;
  int   cycles = 0;  // edges since the request was sampled

  function automatic string op_name(mdu_pkg::mdu_op_t op);
    string base;
    if (op.is_div) begin
      base = op.hi_rem ? "rem" : "div";
    end else begin
      base = op.hi_rem ? "mulh" : "mul";
    end
    return op.is_unsigned ? {base, "u"} : base;
  endfunction

  task automatic report(input logic ok, input string line);
    tests_o++;
    if (!ok) begin
      errors_o++;
    end
    $display("%s", line);
  endtask

  initial begin
    tests_o  = 0;
    errors_o = 0;
  end

  always @(posedge clk) begin
    string name;
    int    lat;
    name = $sformatf("t%0d_%s", index_i, op_name(op_i));
    lat  = (exp_flags_i != 2'b00) ? 1 : `MDU_WIDTH + 3;  // error path finishes at once
    if (rst_n && in_rst) begin
      if ({result_i, done_i, div_by_zero_i, div_overflow_i} !== '0) begin
        report(1'b0, "reset: outputs are not low after reset");
      end else begin
        report(1'b1, "reset: ok");
      end
    end
    if (start_i) begin
      busy   = 1'b1;
      cycles = 0;
    end else if (busy) begin
      cycles++;
      if (done_i) begin
        busy = 1'b0;
        if (cycles - 1 != lat) begin
          report(1'b0, $sformatf("%s: done_o came %0d edges after the request, expected %0d",
                                 name, cycles - 1, lat));
        end else if ({div_by_zero_i, div_overflow_i} !== exp_flags_i) begin
          report(1'b0, $sformatf("%s: wrong flags, div_by_zero_o=%b div_overflow_o=%b, want %b",
                                 name, div_by_zero_i, div_overflow_i, exp_flags_i));
        end else if (exp_flags_i == 2'b00 && result_i !== exp_result_i) begin
          report(1'b0, $sformatf("** Error %s: expected %h, actual %h",
                                 name, exp_result_i, result_i));
        end else begin
          report(1'b1, $sformatf("%s: ok", name));
        end
      end else if (cycles > lat + 4) begin
        busy = 1'b0;
        report(1'b0, $sformatf("%s: no done_o within %0d cycles", name, lat + 4));
      end
    end else if (done_i === 1'b1) begin
      report(1'b0, "done_o pulsed without a pending request");
    end
    in_rst = !rst_n;
  end

endmodule

`default_nettype wire

//--- testbench/mdu_assertions.sv
`default_nettype none

module mdu_assertions (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic done_i,
  input wire logic div_by_zero_i,
  input wire logic div_overflow_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0;  // summed into the final verdict

  done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done_i |=> !done_i)
    else begin
      $error("done_o stayed high for more than one cycle");
      fail_cnt++;
    end

  flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(div_by_zero_i && div_overflow_i))
    else begin
      $error("div_by_zero_o and div_overflow_o high together");
      fail_cnt++;
    end

  // a flag is only meaningful in the done cycle
  flag_with_done: assert property (@(posedge clk) disable iff (!rst_n)
    (div_by_zero_i || div_overflow_i) |-> done_i)
    else begin
      $error("error flag raised without done_o");
      fail_cnt++;
    end

  reset_quiet: assert property (@(posedge clk)
    !rst_n |=> !(done_i || div_by_zero_i || div_overflow_i))
    else begin
      $error("outputs not low during reset");
      fail_cnt++;
    end

endmodule

bind mdu_ctrl mdu_assertions u_assertions (
  .clk            (clk),
  .rst_n          (rst_n),
  .done_i         (done_o),
  .div_by_zero_i  (div_by_zero_o),
  .div_overflow_i (div_overflow_o)
);

`default_nettype wire

//--- rtl/mdu_top.sv
`default_nettype none

`include "mdu_params.svh"

module mdu_top (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             valid_i,
  input  wire mdu_pkg::mdu_op_t op_i,
  input  wire mdu_pkg::word_t   lop_i,
  input  wire mdu_pkg::word_t   rop_i,
  output mdu_pkg::word_t        result_o,
  output logic                  done_o,
  output logic                  div_by_zero_o,
  output logic                  div_overflow_o
);

  mdu_pkg::mdu_op_t op_q;
  mdu_pkg::word_t   mag_a;
  mdu_pkg::word_t   mag_b;
  mdu_pkg::dword_t  acc;
  logic             neg_res;
  logic             neg_rem;

  mdu_ctrl_if u_ctrl_if ();

  mdu_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .ctrl_if        (u_ctrl_if.ctrl),
    .done_o         (done_o),
    .div_by_zero_o  (div_by_zero_o),
    .div_overflow_o (div_overflow_o)
  );

  mdu_operand_unit u_operand_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_i      (op_i),
    .lop_i     (lop_i),
    .rop_i     (rop_i),
    .ctrl_if   (u_ctrl_if.status),
    .op_q_o    (op_q),
    .mag_a_o   (mag_a),
    .mag_b_o   (mag_b),
    .neg_res_o (neg_res),
    .neg_rem_o (neg_rem)
  );

  mdu_iter_unit u_iter_unit (
    .clk     (clk),
    .rst_n   (rst_n),
    .ctrl_if (u_ctrl_if.listen),
    .op_q_i  (op_q),
    .mag_a_i (mag_a),
    .mag_b_i (mag_b),
    .acc_o   (acc)
  );

  mdu_result_unit u_result_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl_if   (u_ctrl_if.listen),
    .op_q_i    (op_q),
    .neg_res_i (neg_res),
    .neg_rem_i (neg_rem),
    .acc_i     (acc),
    .result_o  (result_o)
  );

endmodule

`default_nettype wire

//--- rtl/mdu_result_unit.sv
`default_nettype none

`include "mdu_params.svh"

module mdu_result_unit (
  input  wire logic             clk,
  input  wire logic             rst_n,
  mdu_ctrl_if.listen            ctrl_if,
  input  wire mdu_pkg::mdu_op_t op_q_i,
  input  wire logic             neg_res_i,
  input  wire logic             neg_rem_i,
  input  wire mdu_pkg::dword_t  acc_i,
  output mdu_pkg::word_t        result_o
);

  mdu_pkg::dword_t prod;
  mdu_pkg::word_t  quo;
  mdu_pkg::word_t  rem;
  mdu_pkg::word_t  res_d;

  assign prod = neg_res_i ? -acc_i : acc_i;  // full width so the high word is right
  assign quo  = neg_res_i ? -acc_i[`MDU_WIDTH-1:0] : acc_i[`MDU_WIDTH-1:0];
  assign rem  = neg_rem_i ? -acc_i[2*`MDU_WIDTH-1:`MDU_WIDTH]
                          : acc_i[2*`MDU_WIDTH-1:`MDU_WIDTH];

  always_comb begin
    if (op_q_i.is_div) begin
      res_d = op_q_i.hi_rem ? rem : quo;
    end else begin
      res_d = op_q_i.hi_rem ? prod[2*`MDU_WIDTH-1:`MDU_WIDTH] : prod[`MDU_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_o <= '0;
    end else if (ctrl_if.fix) begin
      result_o <= res_d;
    end
  end

endmodule

`default_nettype wire

//--- rtl/mdu_iter_unit.sv
`default_nettype none

`include "mdu_params.svh"

module mdu_iter_unit (
  input  wire logic             clk,
  input  wire logic             rst_n,
  mdu_ctrl_if.listen            ctrl_if,
  input  wire mdu_pkg::mdu_op_t op_q_i,
  input  wire mdu_pkg::word_t   mag_a_i,
  input  wire mdu_pkg::word_t   mag_b_i,
  output mdu_pkg::dword_t       acc_o
);

  mdu_pkg::dword_t       acc_q;
  mdu_pkg::dword_t       acc_d;
  mdu_pkg::word_t        acc_hi;
  logic [`MDU_WIDTH:0]   mul_sum;   // carry kept for the shift
  logic [`MDU_WIDTH:0]   rem_sh;
  logic [`MDU_WIDTH+1:0] rem_diff;
  logic                  q_bit;

  assign acc_hi = acc_q[2*`MDU_WIDTH-1:`MDU_WIDTH];

  // multiply step
  assign mul_sum = {1'b0, acc_hi} + (acc_q[0] ? {1'b0, mag_b_i} : '0);

  // restoring divide step, partial remainder shifted left by one
  assign rem_sh   = acc_q[2*`MDU_WIDTH-1:`MDU_WIDTH-1];
  assign rem_diff = {1'b0, rem_sh} - {2'b00, mag_b_i};
  assign q_bit    = ~rem_diff[`MDU_WIDTH+1];  // no borrow

  always_comb begin
    if (op_q_i.is_div) begin
      if (q_bit) begin
        acc_d = {rem_diff[`MDU_WIDTH-1:0], acc_q[`MDU_WIDTH-2:0], 1'b1};
      end else begin
        acc_d = {rem_sh[`MDU_WIDTH-1:0], acc_q[`MDU_WIDTH-2:0], 1'b0};
      end
    end else begin
      acc_d = {mul_sum, acc_q[`MDU_WIDTH-1:1]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (ctrl_if.load) begin
      acc_q <= {{`MDU_WIDTH{1'b0}}, mag_a_i};
    end else if (ctrl_if.step) begin
      acc_q <= acc_d;
    end
  end

  assign acc_o = acc_q;

endmodule

`default_nettype wire

//--- rtl/mdu_operand_unit.sv
`default_nettype none

`include "mdu_params.svh"

module mdu_operand_unit (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire mdu_pkg::mdu_op_t op_i,
  input  wire mdu_pkg::word_t   lop_i,
  input  wire mdu_pkg::word_t   rop_i,
  mdu_ctrl_if.status            ctrl_if,
  output mdu_pkg::mdu_op_t      op_q_o,
  output mdu_pkg::word_t        mag_a_o,
  output mdu_pkg::word_t        mag_b_o,
  output logic                  neg_res_o,
  output logic                  neg_rem_o
);

  logic           lop_neg;
  logic           rop_neg;
  mdu_pkg::word_t min_neg;

  assign lop_neg = ~op_i.is_unsigned & lop_i[`MDU_WIDTH-1];
  assign rop_neg = ~op_i.is_unsigned & rop_i[`MDU_WIDTH-1];
  assign min_neg = {1'b1, {(`MDU_WIDTH-1){1'b0}}};

  assign ctrl_if.err = '{
    div_zero: op_i.is_div & (rop_i == '0),
    div_ovf:  op_i.is_div & ~op_i.is_unsigned & (lop_i == min_neg) & (rop_i == '1)
  };

  // left magnitude goes straight into the iteration register on load
  assign mag_a_o = lop_neg ? -lop_i : lop_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      op_q_o    <= '0;
      neg_res_o <= 1'b0;
      neg_rem_o <= 1'b0;
    end else if (ctrl_if.load) begin
      op_q_o    <= op_i;
      neg_res_o <= lop_neg ^ rop_neg;
      neg_rem_o <= lop_neg;  // remainder follows the dividend
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl_if.load) begin
      mag_b_o <= rop_neg ? -rop_i : rop_i;
    end
  end

endmodule

`default_nettype wire

//--- rtl/mdu_ctrl.sv
`default_nettype none

`include "mdu_params.svh"

module mdu_ctrl (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic valid_i,
  mdu_ctrl_if.ctrl  ctrl_if,
  output logic      done_o,
  output logic      div_by_zero_o,
  output logic      div_overflow_o
);

  typedef enum logic [2:0] {
    st_idle,
    st_load,
    st_iter,
    st_fix,
    st_done,
    st_err
  } state_e;

  localparam logic [`MDU_CNT_W-1:0] iter_cnt = `MDU_CNT_W'(`MDU_WIDTH);

  state_e                state_q;
  state_e                state_d;
  logic [`MDU_CNT_W-1:0] cnt_q;
  logic                  last_step;
  mdu_pkg::mdu_err_t     err_q;

  assign last_step = (cnt_q == `MDU_CNT_W'(1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (valid_i) begin
          state_d = (ctrl_if.err != '0) ? st_err : st_load;
        end
      end
      st_load: state_d = st_iter;
      st_iter: begin
        if (last_step) begin
          state_d = st_fix;
        end
      end
      st_fix:  state_d = st_done;
      st_done: state_d = st_idle;
      st_err:  state_d = st_idle;
      default: state_d = st_idle;
    endcase
  end

  assign ctrl_if.load     = (state_q == st_load);
  assign ctrl_if.step     = (state_q == st_iter);
  assign ctrl_if.fix      = (state_q == st_fix);
  assign ctrl_if.err_done = (state_q == st_err);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q        <= st_idle;
      cnt_q          <= '0;
      err_q          <= '0;
      done_o         <= 1'b0;
      div_by_zero_o  <= 1'b0;
      div_overflow_o <= 1'b0;
    end else begin
      state_q <= state_d;
      if (ctrl_if.load) begin
        cnt_q <= iter_cnt;
      end else if (ctrl_if.step) begin
        cnt_q <= cnt_q - 1'b1;
      end
      if (state_q == st_idle && valid_i) begin
        err_q <= ctrl_if.err;  // flags of the accepted request
      end
      // outputs registered, one cycle after DONE or ERR
      done_o         <= (state_q == st_done) | ctrl_if.err_done;
      div_by_zero_o  <= ctrl_if.err_done & err_q.div_zero;
      div_overflow_o <= ctrl_if.err_done & err_q.div_ovf;
    end
  end

endmodule

`default_nettype wire

//--- rtl/mdu_ctrl_if.sv
`default_nettype none

`include "mdu_params.svh"

interface mdu_ctrl_if;

  logic              load;      // capture operands, one cycle
  logic              step;      // one kernel bit per cycle
  logic              fix;       // write result register
  logic              err_done;  // error finish cycle
  mdu_pkg::mdu_err_t err;       // from request inputs, combinational

  modport ctrl (
    output load, step, fix, err_done,
    input  err
  );

  modport status (
    output err,
    input  load
  );

  modport listen (
    input load, step, fix, err_done
  );

endinterface

`default_nettype wire

//--- rtl/mdu_pkg.sv
`default_nettype none

`include "mdu_params.svh"

package mdu_pkg;

  typedef logic [`MDU_WIDTH-1:0] word_t;
  typedef logic [2*`MDU_WIDTH-1:0] dword_t;  // remainder:quotient or product

  // same bit order as the request opcode
  typedef struct packed {
    logic is_div;
    logic hi_rem;
    logic is_unsigned;
  } mdu_op_t;

  typedef struct packed {
    logic div_zero;
    logic div_ovf;
  } mdu_err_t;

endpackage

`default_nettype wire

//--- rtl/mdu_params.svh
`ifndef MDU_PARAMS_SVH
`define MDU_PARAMS_SVH

`define MDU_WIDTH 32
// wide enough to hold MDU_WIDTH itself
`define MDU_CNT_W ($clog2(`MDU_WIDTH) + 1)

`endif
